// ==== ee_serial_port.sv ====
`timescale 1ns/10ps

module ee_serial_port (
	input  logic                        sys_clk,
	input  logic                        xresetl,
	input  logic                        ee_cs_i,
	input  logic                        ee_sk_i,
	input  logic                        ee_di_i,
	input  logic                        wr_busy_i,
	input  serial_eeprom_pkg::ee_word_t rd_data_i,
	output logic                        ee_do_o,
	output logic                        wr_start_o,
	output logic                        wr_all_o,
	output logic                        wr_erase_o,
	output logic                        wr_enable_o,
	output serial_eeprom_pkg::ee_addr_t wr_addr_o,
	output serial_eeprom_pkg::ee_addr_t rd_addr_o,
	output serial_eeprom_pkg::ee_word_t wr_data_o
);

	import serial_eeprom_pkg::*;

	ee_port_state_t     state_q;
	logic               sk_s;            // Registered pins
	logic               sk_prev;
	logic               di_s;
	logic               sk_rise;
	logic [EE_IR_W-1:0] ir_q;            // Start, opcode, address
	ee_word_t           dr_q;            // Write data in, read data out
	logic [3:0]         cnt_q;           // Data bit counter
	logic               ewen_q;          // Write enable flag
	logic               do_q;
	logic               start_q;
	logic [1:0]         ir_op;
	logic [1:0]         ir_sub;

	assign sk_rise = sk_s & ~sk_prev;

	// Opcode fields once the instruction is complete
	assign ir_op  = ir_q[EE_IR_W-2 -: 2];
	assign ir_sub = ir_q[EE_ADDR_W-1 -: 2];

	always_ff @(posedge sys_clk) begin
		start_q <= 1'b0;                                     // Pulse
		if (!xresetl) begin
			sk_s    <= 1'b0;
			sk_prev <= 1'b0;
			di_s    <= 1'b0;
			state_q <= PORT_IDLE;
			ir_q    <= '0;
			dr_q    <= '0;
			cnt_q   <= 4'd0;
			ewen_q  <= 1'b0;
			do_q    <= 1'b1;
		end else begin
			sk_s    <= ee_sk_i;
			sk_prev <= sk_s;
			di_s    <= ee_di_i;
			if (!ee_cs_i) begin                              // Deselect aborts everything
				state_q <= PORT_IDLE;
				ir_q    <= '0;
				dr_q    <= '0;
				cnt_q   <= 4'd0;
				do_q    <= 1'b1;
			end else if (state_q == PORT_WAIT) begin
				// Busy low on do until the sequencer lets go
				if (!wr_busy_i && !start_q) begin
					state_q <= PORT_IDLE;
					do_q    <= 1'b1;                         // Ready
				end
			end else if (sk_rise) begin
				case (state_q)
					PORT_IDLE: begin
						// ir_q[8] set means done, wait for deselect
						if (!ir_q[EE_IR_W-1]) begin
							ir_q <= {ir_q[EE_IR_W-2:0], di_s};
							if (ir_q[EE_IR_W-2]) begin       // Ninth bit arriving
								case (ir_q[EE_IR_W-3 -: 2])
									OP_READ: begin
										dr_q    <= rd_data_i;
										do_q    <= 1'b0; // Dummy bit
										state_q <= PORT_READ;
									end
									OP_WRITE: begin
										cnt_q   <= 4'd0;
										state_q <= PORT_DATA;
									end
									OP_ERASE: begin
										start_q <= 1'b1;
										do_q    <= 1'b0;
										state_q <= PORT_WAIT;
									end
									default: begin           // OP_EXT
										case (ir_q[EE_ADDR_W-2 -: 2])
											EXT_EWDS: ewen_q <= 1'b0;
											EXT_EWEN: ewen_q <= 1'b1;
											EXT_WRAL: begin
												cnt_q   <= 4'd0;
												state_q <= PORT_DATA;
											end
											default: begin   // ERAL
												start_q <= 1'b1;
												do_q    <= 1'b0;
												state_q <= PORT_WAIT;
											end
										endcase
									end
								endcase
							end
						end
					end
					PORT_DATA: begin
						dr_q  <= {dr_q[EE_DATA_W-2:0], di_s};
						cnt_q <= cnt_q + 4'd1;
						if (cnt_q == 4'd15) begin               // Sixteenth bit
							start_q <= 1'b1;
							do_q    <= 1'b0;
							state_q <= PORT_WAIT;
						end
					end
					PORT_READ: begin
						do_q <= dr_q[EE_DATA_W-1];           // MSB first
						dr_q <= {dr_q[EE_DATA_W-2:0], 1'b0};
					end
					default: state_q <= PORT_IDLE;
				endcase
			end
		end
	end

	// Command fields stay in ir_q and dr_q until deselect
	assign wr_all_o    = (ir_op == OP_EXT) && (ir_sub == EXT_WRAL || ir_sub == EXT_ERAL);
	assign wr_erase_o  = (ir_op == OP_ERASE) || (ir_op == OP_EXT && ir_sub == EXT_ERAL);
	assign wr_addr_o   = ir_q[EE_ADDR_W-1:0];
	assign wr_data_o   = dr_q;
	assign wr_enable_o = ewen_q;
	assign wr_start_o  = start_q;

	// Address is five held bits plus the bit on di now
	assign rd_addr_o = {ir_q[EE_ADDR_W-2:0], di_s};
	assign ee_do_o   = do_q;

endmodule

// ==== ee_word_store.sv ====
`timescale 1ns/10ps

module ee_word_store (
	input  logic                        sys_clk,
	input  logic                        mem_we_i,
	input  serial_eeprom_pkg::ee_addr_t mem_addr_i,
	input  serial_eeprom_pkg::ee_word_t mem_wdata_i,
	input  serial_eeprom_pkg::ee_addr_t rd_addr_i,
	output serial_eeprom_pkg::ee_word_t rd_data_o
);

	import serial_eeprom_pkg::*;

	// Contents are undefined until written, as on a blank part
	ee_word_t mem [0:EE_WORDS-1];

	// Single write port, driven by the sequencer
	always_ff @(posedge sys_clk) begin
		if (mem_we_i) begin
			mem[mem_addr_i] <= mem_wdata_i;
		end
	end

	// Read is combinational so the port can load on the ninth bit
	assign rd_data_o = mem[rd_addr_i];

endmodule

// ==== ee_write_seq.sv ====
`timescale 1ns/10ps

module ee_write_seq (
	input  logic                        sys_clk,
	input  logic                        xresetl,
	input  logic                        wr_start_i,
	input  logic                        wr_all_i,
	input  logic                        wr_erase_i,
	input  logic                        wr_enable_i,
	input  serial_eeprom_pkg::ee_addr_t wr_addr_i,
	input  serial_eeprom_pkg::ee_word_t wr_data_i,
	output logic                        wr_busy_o,
	output logic                        mem_we_o,
	output serial_eeprom_pkg::ee_addr_t mem_addr_o,
	output serial_eeprom_pkg::ee_word_t mem_wdata_o
);

	import serial_eeprom_pkg::*;

	ee_wseq_state_t state_q;
	logic           all_q;         // Sweep over every word
	logic           we_q;
	ee_addr_t       addr_q;
	ee_word_t       data_q;
	logic           last_word;

	assign last_word = (addr_q == ee_addr_t'(EE_WORDS - 1));

	// Control
	always_ff @(posedge sys_clk) begin
		we_q <= 1'b0;                                        // Write strobe is one cycle
		if (!xresetl) begin
			state_q <= WSEQ_IDLE;
			all_q   <= 1'b0;
		end else begin
			case (state_q)
				WSEQ_IDLE: begin
					if (wr_start_i) begin
						all_q   <= wr_all_i;
						state_q <= WSEQ_WRITE;
					end
				end
				WSEQ_WRITE: begin
					we_q    <= wr_enable_i;                  // Protected part writes nothing
					state_q <= WSEQ_NEXT;
				end
				WSEQ_NEXT: begin
					if (all_q && !last_word) begin
						state_q <= WSEQ_WRITE;
					end else if (all_q) begin
						state_q <= WSEQ_IDLE;                // Sweep done, ready at once
					end else begin
						state_q <= WSEQ_END;
					end
				end
				default: state_q <= WSEQ_IDLE;              // WSEQ_END
			endcase
		end
	end

	// Address and data of the write in progress
	always_ff @(posedge sys_clk) begin
		if (state_q == WSEQ_IDLE && wr_start_i) begin
			addr_q <= wr_all_i ? '0 : wr_addr_i;
			data_q <= wr_erase_i ? EE_ERASED : wr_data_i;
		end else if (state_q == WSEQ_NEXT && all_q) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	assign wr_busy_o   = (state_q != WSEQ_IDLE);
	assign mem_we_o    = we_q;
	assign mem_addr_o  = addr_q;
	assign mem_wdata_o = data_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the serial EEPROM testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module serial_eeprom_tb \
	-f serial_eeprom.f \
	-o sim_serial_eeprom

# tee keeps the log even when the run stops early
./obj_dir/sim_serial_eeprom | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi

// ==== serial_eeprom.f ====
serial_eeprom_pkg.sv
ee_word_store.sv
ee_write_seq.sv
ee_serial_port.sv
serial_eeprom.sv
serial_eeprom_chk.sv
serial_eeprom_tb.sv

// ==== serial_eeprom.sv ====
`timescale 1ns/10ps

module serial_eeprom (
	input  logic sys_clk,
	input  logic xresetl,
	input  logic ee_cs_i,
	input  logic ee_sk_i,
	input  logic ee_di_i,
	output logic ee_do_o
);

	import serial_eeprom_pkg::*;

	// Port to sequencer
	logic     wr_start;
	logic     wr_all;
	logic     wr_erase;
	logic     wr_enable;
	logic     wr_busy;
	ee_addr_t wr_addr;
	ee_word_t wr_data;

	// Sequencer and port to store
	logic     mem_we;
	ee_addr_t mem_addr;
	ee_word_t mem_wdata;
	ee_addr_t rd_addr;
	ee_word_t rd_data;

	ee_serial_port u_port (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.ee_cs_i     (ee_cs_i),
		.ee_sk_i     (ee_sk_i),
		.ee_di_i     (ee_di_i),
		.wr_busy_i   (wr_busy),
		.rd_data_i   (rd_data),
		.ee_do_o     (ee_do_o),
		.wr_start_o  (wr_start),
		.wr_all_o    (wr_all),
		.wr_erase_o  (wr_erase),
		.wr_enable_o (wr_enable),
		.wr_addr_o   (wr_addr),
		.rd_addr_o   (rd_addr),
		.wr_data_o   (wr_data)
	);

	ee_write_seq u_seq (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.wr_start_i  (wr_start),
		.wr_all_i    (wr_all),
		.wr_erase_i  (wr_erase),
		.wr_enable_i (wr_enable),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.wr_busy_o   (wr_busy),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata)
	);

	ee_word_store u_store (
		.sys_clk     (sys_clk),
		.mem_we_i    (mem_we),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.rd_addr_i   (rd_addr),
		.rd_data_o   (rd_data)
	);

endmodule

// ==== serial_eeprom_chk.sv ====
`timescale 1ns/10ps

module serial_eeprom_chk (
	input logic                        sys_clk,
	input logic                        xresetl,
	input logic                        ee_cs_i,
	input logic                        ee_do_i,
	input logic                        wr_start_i,
	input logic                        wr_busy_i,
	input logic                        wr_all_i,
	input logic                        wr_enable_i,
	input serial_eeprom_pkg::ee_addr_t wr_addr_i,
	input logic                        mem_we_i,
	input serial_eeprom_pkg::ee_addr_t mem_addr_i
);

	logic [7:0] busy_cycles;                            // Saturating count since the last start

	always_ff @(posedge sys_clk) begin
		if (!xresetl || wr_start_i) begin
			busy_cycles <= 8'd0;
		end else if (wr_busy_i && busy_cycles != 8'hff) begin
			busy_cycles <= busy_cycles + 8'd1;
		end
	end

	// Deselect parks do high
	a_deselect_do_high: assert property (@(posedge sys_clk) disable iff (!xresetl)
		!ee_cs_i |=> ee_do_i) else $error("do not high after deselect");

	a_we_needs_enable: assert property (@(posedge sys_clk) disable iff (!xresetl)
		$rose(mem_we_i) |-> wr_enable_i) else $error("write while protected");

	a_we_inside_busy: assert property (@(posedge sys_clk) disable iff (!xresetl)
		mem_we_i |-> wr_busy_i) else $error("write strobe outside busy");

	// Single word lands on the address the port still holds
	a_we_single_addr: assert property (@(posedge sys_clk) disable iff (!xresetl)
		(mem_we_i && !wr_all_i) |-> (mem_addr_i == wr_addr_i))
		else $error("single write to wrong address");

	// Full sweep drops busy 129 cycles after start
	a_busy_bound: assert property (@(posedge sys_clk) disable iff (!xresetl)
		wr_busy_i |-> busy_cycles <= 8'd128) else $error("busy held too long");

endmodule

bind serial_eeprom serial_eeprom_chk u_chk (
	.sys_clk     (sys_clk),
	.xresetl     (xresetl),
	.ee_cs_i     (ee_cs_i),
	.ee_do_i     (ee_do_o),
	.wr_start_i  (wr_start),
	.wr_busy_i   (wr_busy),
	.wr_all_i    (wr_all),
	.wr_enable_i (wr_enable),
	.wr_addr_i   (wr_addr),
	.mem_we_i    (mem_we),
	.mem_addr_i  (mem_addr)
);

// ==== serial_eeprom_pkg.sv ====
package serial_eeprom_pkg;

	// Array geometry
	localparam int EE_ADDR_W = 6;                  // Word address bits
	localparam int EE_DATA_W = 16;                 // Bits per word
	localparam int EE_WORDS  = 1 << EE_ADDR_W;     // 64 words
	localparam int EE_IR_W   = 3 + EE_ADDR_W;      // Start bit, opcode, address

	typedef logic [EE_ADDR_W-1:0] ee_addr_t;
	typedef logic [EE_DATA_W-1:0] ee_word_t;

	localparam ee_word_t EE_ERASED = '1;           // Erased cells read as ones

	// Opcodes, sent right after the start bit
	localparam logic [1:0] OP_READ  = 2'b10;
	localparam logic [1:0] OP_WRITE = 2'b01;
	localparam logic [1:0] OP_ERASE = 2'b11;
	localparam logic [1:0] OP_EXT   = 2'b00;       // Sub-code in top address bits

	// Sub-codes under OP_EXT
	localparam logic [1:0] EXT_EWDS = 2'b00;
	localparam logic [1:0] EXT_WRAL = 2'b01;
	localparam logic [1:0] EXT_ERAL = 2'b10;
	localparam logic [1:0] EXT_EWEN = 2'b11;

	typedef enum logic [1:0] {
		PORT_IDLE,                                 // Collecting instruction bits
		PORT_DATA,                                 // Collecting write data
		PORT_READ,                                 // Shifting out a word
		PORT_WAIT                                  // Busy, sequencer running
	} ee_port_state_t;

	typedef enum logic [1:0] {
		WSEQ_IDLE,
		WSEQ_WRITE,                                // Issue one word write
		WSEQ_NEXT,                                 // Step address or finish
		WSEQ_END
	} ee_wseq_state_t;

endpackage

// ==== serial_eeprom_tb.sv ====
`timescale 1ns/10ps

module serial_eeprom_tb;

	import serial_eeprom_pkg::*;

	localparam int SK_HALF    = 4;                      // sys_clk cycles per sk phase
	localparam int BUSY_WAIT  = 8;
	localparam int READY_WAIT = 400;

	logic       sys_clk;
	logic       xresetl;
	logic       ee_cs;
	logic       ee_sk;
	logic       ee_di;
	logic       ee_do;
	logic [7:0] lfsr_q;
	logic       wr_en_model;                            // Expected write enable flag
	ee_word_t   model [0:EE_WORDS-1];
	ee_addr_t   addr_list [0:7];                        // Targets of the first writes

	serial_eeprom u_serial_eeprom (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.ee_cs_i (ee_cs),
		.ee_sk_i (ee_sk),
		.ee_di_i (ee_di),
		.ee_do_o (ee_do)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// Taps 8 6 5 4, maximal length
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic random_bits(input int n, output ee_word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);                 // One step per bit
			v      = {v[EE_DATA_W-2:0], lfsr_q[0]};
		end
	endtask

	function automatic ee_word_t instr(input logic [1:0] op, input ee_addr_t a);
		return {7'd0, 1'b1, op, a};                     // Start bit leads
	endfunction

	task automatic tick();
		@(posedge sys_clk);
		#2;                                             // Just after the edge
	endtask

	task automatic fail_value(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic abort_run(input string msg);
		$display("%s at %0t ns", msg, $time);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic select();
		ee_cs = 1'b1;
		tick();
	endtask

	task automatic deselect();
		ee_cs = 1'b0;
		ee_sk = 1'b0;
		ee_di = 1'b0;
		repeat (2) tick();
		assert (ee_do) else fail_value("do low while deselected");
	endtask

	// MSB first, one full sk period per bit
	task automatic send_bits(input ee_word_t val, input int n);
		for (int i = n - 1; i >= 0; i--) begin
			ee_di = val[i];
			ee_sk = 1'b1;
			repeat (SK_HALF) tick();
			ee_sk = 1'b0;
			repeat (SK_HALF) tick();
		end
	endtask

	// Final bit of a write command, do drops to busy while sk is high
	task automatic send_last_bit(input logic b);
		int n;
		n     = 0;
		ee_di = b;
		ee_sk = 1'b1;
		while (ee_do && n < BUSY_WAIT) begin
			tick();
			n++;
		end
		assert (!ee_do) else abort_run("Timeout waiting for busy low on do");
		ee_sk = 1'b0;
		repeat (SK_HALF) tick();
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ee_do && n < READY_WAIT) begin
			tick();
			n++;
		end
		assert (ee_do) else abort_run("Timeout waiting for ready on do");
	endtask

	task automatic set_enable(input logic [1:0] sub);
		select();
		send_bits(instr(OP_EXT, {sub, 4'b0000}), EE_IR_W);
		deselect();
		wr_en_model = (sub == EXT_EWEN);
	endtask

	// WRITE, ERASE, WRAL or ERAL; model follows only when enabled
	task automatic run_write(input logic [1:0] op, input ee_addr_t a, input ee_word_t d);
		logic all_words;
		logic is_erase;
		all_words = (op == OP_EXT);
		is_erase  = (op == OP_ERASE) || (all_words && a[EE_ADDR_W-1 -: 2] == EXT_ERAL);
		select();
		if (is_erase) begin
			send_bits(instr(op, a) >> 1, EE_IR_W - 1);
			send_last_bit(a[0]);
		end else begin
			send_bits(instr(op, a), EE_IR_W);
			send_bits(d >> 1, EE_DATA_W - 1);
			send_last_bit(d[0]);
		end
		wait_ready();
		deselect();
		for (int i = 0; i < EE_WORDS; i++) begin
			if (wr_en_model && (all_words || ee_addr_t'(i) == a)) begin
				model[i] = is_erase ? EE_ERASED : d;
			end
		end
	endtask

	task automatic read_word(input ee_addr_t a, output ee_word_t v);
		v = '0;
		select();
		send_bits(instr(OP_READ, a), EE_IR_W);
		assert (!ee_do) else fail_value($sformatf("dummy bit of read %0d not 0", a));
		ee_di = 1'b0;
		for (int i = 0; i < EE_DATA_W; i++) begin
			ee_sk = 1'b1;
			repeat (SK_HALF) tick();
			ee_sk = 1'b0;
			repeat (SK_HALF) tick();
			v = {v[EE_DATA_W-2:0], ee_do};               // Settled since the rise
		end
		deselect();
	endtask

	task automatic check_read(input ee_addr_t a);
		ee_word_t got;
		read_word(a, got);
		assert (got == model[a]) else
			fail_value($sformatf("addr %0d expected %h got %h", a, model[a], got));
	endtask

	initial begin
		ee_word_t d;
		ee_word_t r;
		ee_cs       = 1'b0;
		ee_sk       = 1'b0;
		ee_di       = 1'b0;
		xresetl     = 1'b0;
		wr_en_model = 1'b0;
		lfsr_q      = 8'd249;
		repeat (2) tick();
		xresetl = 1'b1;
		tick();
		assert (ee_do) else fail_value("do low after reset");

		// Random words to random addresses, then read back
		set_enable(EXT_EWEN);
		for (int i = 0; i < 8; i++) begin
			random_bits(EE_ADDR_W, r);
			addr_list[i] = r[EE_ADDR_W-1:0];
			random_bits(EE_DATA_W, d);
			run_write(OP_WRITE, addr_list[i], d);
		end
		for (int i = 0; i < 8; i++) begin
			check_read(addr_list[i]);
		end

		// Protected part, busy still shown but nothing changes
		set_enable(EXT_EWDS);
		random_bits(EE_DATA_W, d);
		run_write(OP_WRITE, addr_list[0], d);
		run_write(OP_ERASE, addr_list[1], '0);
		check_read(addr_list[0]);
		check_read(addr_list[1]);

		set_enable(EXT_EWEN);
		run_write(OP_ERASE, addr_list[2], '0);
		check_read(addr_list[2]);

		// Whole array sweeps
		random_bits(EE_DATA_W, d);
		run_write(OP_EXT, {EXT_WRAL, 4'b0000}, d);
		for (int i = 0; i < 4; i++) begin
			random_bits(EE_ADDR_W, r);
			check_read(r[EE_ADDR_W-1:0]);
		end
		run_write(OP_EXT, {EXT_ERAL, 4'b0000}, '0);
		for (int i = 0; i < 4; i++) begin
			random_bits(EE_ADDR_W, r);
			check_read(r[EE_ADDR_W-1:0]);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
